//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  parameter int XLEN = 32;

  // funct3 width carried for branches and stores
  parameter int BR_OP_BITS = 3;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [6:0]      opcode_t;

  // funct7[5] over funct3
  typedef logic [3:0] alu_op_t;

  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_FENCE  = 7'b0001111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SUB  = 4'b1000;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_SRA  = 4'b1101;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_AND  = 4'b0111;

  // what execute does with a decoded instruction
  typedef enum logic [2:0] {
    KIND_ALU,
    KIND_BRANCH,
    KIND_JUMP,
    KIND_STORE,
    KIND_NOP,
    KIND_ILLEGAL
  } kind_t;

endpackage

`default_nettype wire

//--- logic/rv_regfile.sv
`default_nettype none

module rv_regfile #(
  parameter int XLEN_P = rv_pkg::XLEN
) (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_idx_t  raddr1_i,
  input  rv_pkg::reg_idx_t  raddr2_i,
  output logic [XLEN_P-1:0] rdata1_o,
  output logic [XLEN_P-1:0] rdata2_o,
  input  logic              we_i,
  input  rv_pkg::reg_idx_t  waddr_i,
  input  logic [XLEN_P-1:0] wdata_i
);

  // x0 has no storage
  logic [XLEN_P-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  // the result stage filters x0 writes before they get here
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    we_i |-> waddr_i != '0);

endmodule

`default_nettype wire

//--- logic/rv_decode.sv
`default_nettype none

module rv_decode #(
  parameter int XLEN_P = rv_pkg::XLEN
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid_i,
  input  rv_pkg::inst_t                 in_inst_i,
  input  logic [XLEN_P-1:0]             in_pc_i,
  output logic                          in_ready_o,
  output rv_pkg::reg_idx_t              rs1_idx_o,
  output rv_pkg::reg_idx_t              rs2_idx_o,
  input  logic [XLEN_P-1:0]             rs1_data_i,
  input  logic [XLEN_P-1:0]             rs2_data_i,
  input  logic                          ex_pend_valid_i,
  input  rv_pkg::reg_idx_t              ex_pend_rd_i,
  input  logic                          res_pend_valid_i,
  input  rv_pkg::reg_idx_t              res_pend_rd_i,
  output logic                          dec_valid_o,
  output rv_pkg::alu_op_t               dec_alu_op_o,
  output logic [XLEN_P-1:0]             dec_op1_o,
  output logic [XLEN_P-1:0]             dec_op2_o,
  output logic [XLEN_P-1:0]             dec_jbase_o,
  output logic [XLEN_P-1:0]             dec_imm_o,
  output rv_pkg::reg_idx_t              dec_rd_o,
  output logic                          dec_wen_o,
  output rv_pkg::kind_t                 dec_kind_o,
  output logic [rv_pkg::BR_OP_BITS-1:0] dec_funct3_o,
  output logic [XLEN_P-1:0]             dec_store_data_o,
  output logic [XLEN_P-1:0]             dec_pc_o,
  input  logic                          ex_ready_i
);
  import rv_pkg::*;

  logic              valid_q;
  inst_t             inst_q;
  logic [XLEN_P-1:0] pc_q;
  opcode_t           opcode;
  word_t             imm_i, imm_s, imm_b, imm_u, imm_j, imm32;
  logic              uses_rs1, uses_rs2;
  logic              hit1, hit2, stall;

  assign opcode       = inst_q[6:0];
  assign rs1_idx_o    = inst_q[19:15];
  assign rs2_idx_o    = inst_q[24:20];
  assign dec_rd_o     = inst_q[11:7];
  assign dec_funct3_o = inst_q[14:12];
  assign dec_pc_o     = pc_q;

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC: imm32 = imm_u;
      OP_JAL:           imm32 = imm_j;
      OP_BRANCH:        imm32 = imm_b;
      OP_STORE:         imm32 = imm_s;
      default:          imm32 = imm_i;
    endcase
  end

  assign dec_imm_o        = XLEN_P'($signed(imm32));
  assign dec_store_data_o = rs2_data_i;

  always_comb begin
    dec_alu_op_o = ALU_ADD;
    dec_op1_o    = rs1_data_i;
    dec_op2_o    = rs2_data_i;
    dec_jbase_o  = rs1_data_i;
    dec_kind_o   = KIND_ILLEGAL;
    dec_wen_o    = 1'b0;
    uses_rs1     = 1'b0;
    uses_rs2     = 1'b0;
    case (opcode)
      OP_LUI: begin
        dec_op1_o  = '0;
        dec_op2_o  = dec_imm_o;
        dec_kind_o = KIND_ALU;
        dec_wen_o  = 1'b1;
      end
      OP_AUIPC: begin
        dec_op1_o  = pc_q;
        dec_op2_o  = dec_imm_o;
        dec_kind_o = KIND_ALU;
        dec_wen_o  = 1'b1;
      end
      OP_JAL, OP_JALR: begin
        // link value is pc + 4 through the ALU
        dec_op1_o   = pc_q;
        dec_op2_o   = XLEN_P'(4);
        dec_jbase_o = (opcode == OP_JAL) ? pc_q : rs1_data_i;
        dec_kind_o  = KIND_JUMP;
        dec_wen_o   = 1'b1;
        uses_rs1    = (opcode == OP_JALR);
      end
      OP_BRANCH: begin
        dec_jbase_o = pc_q;
        dec_kind_o  = KIND_BRANCH;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;
      end
      OP_STORE: begin
        dec_kind_o = KIND_STORE;
        uses_rs1   = 1'b1;
        uses_rs2   = 1'b1;
      end
      OP_IMM: begin
        dec_alu_op_o = {(inst_q[14:12] == 3'b101) ? inst_q[30] : 1'b0, inst_q[14:12]};
        dec_op2_o    = dec_imm_o;
        dec_kind_o   = KIND_ALU;
        dec_wen_o    = 1'b1;
        uses_rs1     = 1'b1;
      end
      OP_REG: begin
        dec_alu_op_o = {inst_q[30], inst_q[14:12]};
        dec_kind_o   = KIND_ALU;
        dec_wen_o    = 1'b1;
        uses_rs1     = 1'b1;
        uses_rs2     = 1'b1;
      end
      OP_FENCE:           dec_kind_o = KIND_NOP;
      OP_LOAD, OP_SYSTEM: dec_kind_o = KIND_ILLEGAL;
      default:            dec_kind_o = KIND_ILLEGAL;
    endcase
  end

  // hold the item until older writers of its sources have written back
  assign hit1 = uses_rs1 && rs1_idx_o != '0 &&
                ((ex_pend_valid_i && ex_pend_rd_i == rs1_idx_o) ||
                 (res_pend_valid_i && res_pend_rd_i == rs1_idx_o));
  assign hit2 = uses_rs2 && rs2_idx_o != '0 &&
                ((ex_pend_valid_i && ex_pend_rd_i == rs2_idx_o) ||
                 (res_pend_valid_i && res_pend_rd_i == rs2_idx_o));
  assign stall = hit1 || hit2;

  assign dec_valid_o = valid_q && !stall;
  assign in_ready_o  = !valid_q || (dec_valid_o && ex_ready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      valid_q <= 1'b1;
    end else if (dec_valid_o && ex_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      inst_q <= in_inst_i;
      pc_q   <= in_pc_i;
    end
  end

  // an offered item stays offered; the hazard cannot come back while it waits
  a_dec_hold: assert property (@(posedge clk) disable iff (rst)
    dec_valid_o && !ex_ready_i |=> dec_valid_o && valid_q && $stable(dec_pc_o));

endmodule

`default_nettype wire

//--- logic/rv_execute.sv
`default_nettype none

module rv_execute #(
  parameter int XLEN_P = rv_pkg::XLEN
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          dec_valid_i,
  input  rv_pkg::alu_op_t               dec_alu_op_i,
  input  logic [XLEN_P-1:0]             dec_op1_i,
  input  logic [XLEN_P-1:0]             dec_op2_i,
  input  logic [XLEN_P-1:0]             dec_jbase_i,
  input  logic [XLEN_P-1:0]             dec_imm_i,
  input  rv_pkg::reg_idx_t              dec_rd_i,
  input  logic                          dec_wen_i,
  input  rv_pkg::kind_t                 dec_kind_i,
  input  logic [rv_pkg::BR_OP_BITS-1:0] dec_funct3_i,
  input  logic [XLEN_P-1:0]             dec_store_data_i,
  input  logic [XLEN_P-1:0]             dec_pc_i,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o,
  output rv_pkg::reg_idx_t              ex_rd_o,
  output logic                          ex_wen_o,
  output logic [XLEN_P-1:0]             ex_wdata_o,
  output logic [XLEN_P-1:0]             ex_next_pc_o,
  output logic                          ex_store_o,
  output logic [XLEN_P-1:0]             ex_store_addr_o,
  output logic [XLEN_P-1:0]             ex_store_data_o,
  output logic [XLEN_P/8-1:0]           ex_store_strb_o,
  output logic                          ex_illegal_o,
  output logic [XLEN_P-1:0]             ex_pc_o,
  output logic                          ex_pend_valid_o,
  output rv_pkg::reg_idx_t              ex_pend_rd_o,
  input  logic                          res_ready_i
);
  import rv_pkg::*;

  localparam int SH_W   = $clog2(XLEN_P);
  localparam int STRB_W = XLEN_P / 8;
  localparam int OFF_W  = $clog2(STRB_W);

  logic                accept;
  logic [SH_W-1:0]     shamt;
  logic                lt_s, lt_u, taken;
  logic [XLEN_P-1:0]   alu_res, target, next_pc;
  logic [OFF_W-1:0]    lane;
  logic [STRB_W-1:0]   size_mask;

  assign shamt = dec_op2_i[SH_W-1:0];
  assign lt_s  = $signed(dec_op1_i) < $signed(dec_op2_i);
  assign lt_u  = dec_op1_i < dec_op2_i;

  always_comb begin
    case (dec_alu_op_i)
      ALU_SUB:  alu_res = dec_op1_i - dec_op2_i;
      ALU_SLL:  alu_res = dec_op1_i << shamt;
      ALU_SLT:  alu_res = XLEN_P'(lt_s);
      ALU_SLTU: alu_res = XLEN_P'(lt_u);
      ALU_XOR:  alu_res = dec_op1_i ^ dec_op2_i;
      ALU_SRL:  alu_res = dec_op1_i >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(dec_op1_i) >>> shamt);
      ALU_OR:   alu_res = dec_op1_i | dec_op2_i;
      ALU_AND:  alu_res = dec_op1_i & dec_op2_i;
      ALU_ADD:  alu_res = dec_op1_i + dec_op2_i;
      default:  alu_res = dec_op1_i + dec_op2_i;
    endcase
  end

  always_comb begin
    case (dec_funct3_i)
      3'b000:  taken = dec_op1_i == dec_op2_i;
      3'b001:  taken = dec_op1_i != dec_op2_i;
      3'b100:  taken = lt_s;
      3'b101:  taken = !lt_s;
      3'b110:  taken = lt_u;
      3'b111:  taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  // shared by jumps, taken branches and store addresses
  assign target = dec_jbase_i + dec_imm_i;

  always_comb begin
    next_pc = dec_pc_i + XLEN_P'(4);
    if (dec_kind_i == KIND_JUMP) begin
      next_pc = {target[XLEN_P-1:1], 1'b0};
    end else if (dec_kind_i == KIND_BRANCH && taken) begin
      next_pc = target;
    end
  end

  assign lane = target[OFF_W-1:0];

  always_comb begin
    case (dec_funct3_i[1:0])
      2'b00:   size_mask = STRB_W'(1);
      2'b01:   size_mask = STRB_W'(2'b11);
      2'b10:   size_mask = STRB_W'(4'hf);
      default: size_mask = '1;
    endcase
  end

  assign ex_ready_o = !ex_valid_o || res_ready_i;
  assign accept     = dec_valid_i && ex_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid_o <= 1'b0;
    end else if (accept) begin
      ex_valid_o <= 1'b1;
    end else if (res_ready_i) begin
      ex_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ex_rd_o         <= dec_rd_i;
      ex_wen_o        <= dec_wen_i;
      ex_wdata_o      <= alu_res;
      ex_next_pc_o    <= next_pc;
      ex_store_o      <= dec_kind_i == KIND_STORE;
      ex_store_addr_o <= target;
      ex_store_data_o <= dec_store_data_i << {lane, 3'b000};
      ex_store_strb_o <= size_mask << lane;
      ex_illegal_o    <= dec_kind_i == KIND_ILLEGAL;
      ex_pc_o         <= dec_pc_i;
    end
  end

  assign ex_pend_valid_o = ex_valid_o && ex_wen_o && ex_rd_o != '0;
  assign ex_pend_rd_o    = ex_rd_o;

  a_store_no_wen: assert property (@(posedge clk) disable iff (rst)
    ex_valid_o |-> !(ex_store_o && ex_wen_o));

endmodule

`default_nettype wire

//--- logic/rv_result.sv
`default_nettype none

module rv_result #(
  parameter int XLEN_P = rv_pkg::XLEN
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                ex_valid_i,
  input  rv_pkg::reg_idx_t    ex_rd_i,
  input  logic                ex_wen_i,
  input  logic [XLEN_P-1:0]   ex_wdata_i,
  input  logic [XLEN_P-1:0]   ex_next_pc_i,
  input  logic                ex_store_i,
  input  logic [XLEN_P-1:0]   ex_store_addr_i,
  input  logic [XLEN_P-1:0]   ex_store_data_i,
  input  logic [XLEN_P/8-1:0] ex_store_strb_i,
  input  logic                ex_illegal_i,
  input  logic [XLEN_P-1:0]   ex_pc_i,
  output logic                res_ready_o,
  output logic                rf_we_o,
  output rv_pkg::reg_idx_t    rf_waddr_o,
  output logic [XLEN_P-1:0]   rf_wdata_o,
  output logic                res_pend_valid_o,
  output rv_pkg::reg_idx_t    res_pend_rd_o,
  output logic                res_valid_o,
  output logic [XLEN_P-1:0]   res_pc_o,
  output rv_pkg::reg_idx_t    res_rd_o,
  output logic                res_wen_o,
  output logic [XLEN_P-1:0]   res_wdata_o,
  output logic [XLEN_P-1:0]   res_next_pc_o,
  output logic                res_store_o,
  output logic [XLEN_P-1:0]   res_store_addr_o,
  output logic [XLEN_P-1:0]   res_store_data_o,
  output logic [XLEN_P/8-1:0] res_store_strb_o,
  output logic                res_illegal_o,
  input  logic                res_ready_i
);

  logic accept;

  assign res_ready_o = !res_valid_o || res_ready_i;
  assign accept      = ex_valid_i && res_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid_o <= 1'b0;
    end else if (accept) begin
      res_valid_o <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_pc_o         <= ex_pc_i;
      res_rd_o         <= ex_rd_i;
      res_wen_o        <= ex_wen_i;
      res_wdata_o      <= ex_wdata_i;
      res_next_pc_o    <= ex_next_pc_i;
      res_store_o      <= ex_store_i;
      res_store_addr_o <= ex_store_addr_i;
      res_store_data_o <= ex_store_data_i;
      res_store_strb_o <= ex_store_strb_i;
      res_illegal_o    <= ex_illegal_i;
    end
  end

  // commit on the edge where the retire report is taken
  assign res_pend_valid_o = res_valid_o && res_wen_o && res_rd_o != '0;
  assign res_pend_rd_o    = res_rd_o;
  assign rf_we_o          = res_pend_valid_o && res_ready_i;
  assign rf_waddr_o       = res_rd_o;
  assign rf_wdata_o       = res_wdata_o;

endmodule

`default_nettype wire

//--- logic/rv_core_top.sv
`default_nettype none

module rv_core_top #(
  parameter int XLEN_P = rv_pkg::XLEN
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  input  rv_pkg::inst_t       in_inst_i,
  input  logic [XLEN_P-1:0]   in_pc_i,
  output logic                in_ready_o,
  output logic                res_valid_o,
  output logic [XLEN_P-1:0]   res_pc_o,
  output rv_pkg::reg_idx_t    res_rd_o,
  output logic                res_wen_o,
  output logic [XLEN_P-1:0]   res_wdata_o,
  output logic [XLEN_P-1:0]   res_next_pc_o,
  output logic                res_store_o,
  output logic [XLEN_P-1:0]   res_store_addr_o,
  output logic [XLEN_P-1:0]   res_store_data_o,
  output logic [XLEN_P/8-1:0] res_store_strb_o,
  output logic                res_illegal_o,
  input  logic                res_ready_i
);
  import rv_pkg::*;

  reg_idx_t               rs1_idx, rs2_idx, rf_waddr;
  logic [XLEN_P-1:0]      rs1_data, rs2_data, rf_wdata;
  logic                   rf_we;
  logic                   ex_pend_valid, res_pend_valid;
  reg_idx_t               ex_pend_rd, res_pend_rd;

  logic                   dec_valid, dec_wen, ex_ready;
  alu_op_t                dec_alu_op;
  logic [XLEN_P-1:0]      dec_op1, dec_op2, dec_jbase, dec_imm, dec_store_data, dec_pc;
  reg_idx_t               dec_rd;
  kind_t                  dec_kind;
  logic [BR_OP_BITS-1:0]  dec_funct3;

  logic                   ex_valid, ex_wen, ex_store, ex_illegal, res_ready;
  reg_idx_t               ex_rd;
  logic [XLEN_P-1:0]      ex_wdata, ex_next_pc, ex_store_addr, ex_store_data, ex_pc;
  logic [XLEN_P/8-1:0]    ex_store_strb;

  rv_regfile #(.XLEN_P(XLEN_P)) u_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (rs1_idx),
    .raddr2_i (rs2_idx),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

  rv_decode #(.XLEN_P(XLEN_P)) u_decode (
    .clk              (clk),
    .rst              (rst),
    .in_valid_i       (in_valid_i),
    .in_inst_i        (in_inst_i),
    .in_pc_i          (in_pc_i),
    .in_ready_o       (in_ready_o),
    .rs1_idx_o        (rs1_idx),
    .rs2_idx_o        (rs2_idx),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .ex_pend_valid_i  (ex_pend_valid),
    .ex_pend_rd_i     (ex_pend_rd),
    .res_pend_valid_i (res_pend_valid),
    .res_pend_rd_i    (res_pend_rd),
    .dec_valid_o      (dec_valid),
    .dec_alu_op_o     (dec_alu_op),
    .dec_op1_o        (dec_op1),
    .dec_op2_o        (dec_op2),
    .dec_jbase_o      (dec_jbase),
    .dec_imm_o        (dec_imm),
    .dec_rd_o         (dec_rd),
    .dec_wen_o        (dec_wen),
    .dec_kind_o       (dec_kind),
    .dec_funct3_o     (dec_funct3),
    .dec_store_data_o (dec_store_data),
    .dec_pc_o         (dec_pc),
    .ex_ready_i       (ex_ready)
  );

  rv_execute #(.XLEN_P(XLEN_P)) u_execute (
    .clk              (clk),
    .rst              (rst),
    .dec_valid_i      (dec_valid),
    .dec_alu_op_i     (dec_alu_op),
    .dec_op1_i        (dec_op1),
    .dec_op2_i        (dec_op2),
    .dec_jbase_i      (dec_jbase),
    .dec_imm_i        (dec_imm),
    .dec_rd_i         (dec_rd),
    .dec_wen_i        (dec_wen),
    .dec_kind_i       (dec_kind),
    .dec_funct3_i     (dec_funct3),
    .dec_store_data_i (dec_store_data),
    .dec_pc_i         (dec_pc),
    .ex_ready_o       (ex_ready),
    .ex_valid_o       (ex_valid),
    .ex_rd_o          (ex_rd),
    .ex_wen_o         (ex_wen),
    .ex_wdata_o       (ex_wdata),
    .ex_next_pc_o     (ex_next_pc),
    .ex_store_o       (ex_store),
    .ex_store_addr_o  (ex_store_addr),
    .ex_store_data_o  (ex_store_data),
    .ex_store_strb_o  (ex_store_strb),
    .ex_illegal_o     (ex_illegal),
    .ex_pc_o          (ex_pc),
    .ex_pend_valid_o  (ex_pend_valid),
    .ex_pend_rd_o     (ex_pend_rd),
    .res_ready_i      (res_ready)
  );

  rv_result #(.XLEN_P(XLEN_P)) u_result (
    .clk              (clk),
    .rst              (rst),
    .ex_valid_i       (ex_valid),
    .ex_rd_i          (ex_rd),
    .ex_wen_i         (ex_wen),
    .ex_wdata_i       (ex_wdata),
    .ex_next_pc_i     (ex_next_pc),
    .ex_store_i       (ex_store),
    .ex_store_addr_i  (ex_store_addr),
    .ex_store_data_i  (ex_store_data),
    .ex_store_strb_i  (ex_store_strb),
    .ex_illegal_i     (ex_illegal),
    .ex_pc_i          (ex_pc),
    .res_ready_o      (res_ready),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .res_pend_valid_o (res_pend_valid),
    .res_pend_rd_o    (res_pend_rd),
    .res_valid_o      (res_valid_o),
    .res_pc_o         (res_pc_o),
    .res_rd_o         (res_rd_o),
    .res_wen_o        (res_wen_o),
    .res_wdata_o      (res_wdata_o),
    .res_next_pc_o    (res_next_pc_o),
    .res_store_o      (res_store_o),
    .res_store_addr_o (res_store_addr_o),
    .res_store_data_o (res_store_data_o),
    .res_store_strb_o (res_store_strb_o),
    .res_illegal_o    (res_illegal_o),
    .res_ready_i      (res_ready_i)
  );

endmodule

`default_nettype wire

//--- test/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

  localparam int NUM_VEC    = 39;
  localparam int FIELDS     = 11;
  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 16;
  localparam int LIMIT      = RST_CYCLES + 40 * NUM_VEC;

  // column positions in the vector file
  localparam int F_INST    = 0;
  localparam int F_PC      = 1;
  localparam int F_RD      = 2;
  localparam int F_WEN     = 3;
  localparam int F_WDATA   = 4;
  localparam int F_NEXT_PC = 5;
  localparam int F_STORE   = 6;
  localparam int F_ADDR    = 7;
  localparam int F_DATA    = 8;
  localparam int F_STRB    = 9;
  localparam int F_ILLEGAL = 10;

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic [31:0] in_inst_i;
  logic [31:0] in_pc_i;
  logic        in_ready_o;
  logic        res_valid_o;
  logic [31:0] res_pc_o;
  logic [4:0]  res_rd_o;
  logic        res_wen_o;
  logic [31:0] res_wdata_o;
  logic [31:0] res_next_pc_o;
  logic        res_store_o;
  logic [31:0] res_store_addr_o;
  logic [31:0] res_store_data_o;
  logic [3:0]  res_store_strb_o;
  logic        res_illegal_o;
  logic        res_ready_i;

  logic [31:0] vec_mem [0:NUM_VEC*FIELDS-1];
  logic [31:0] lfsr_q;
  int          retired;

  rv_core_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bit(output logic b);
    lfsr_q = lfsr_step(lfsr_q);
    b      = lfsr_q[0];
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s: got %08h, expected %08h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_retire(input int n);
    int base;
    base = n * FIELDS;
    check_value("res_pc_o", res_pc_o, vec_mem[base + F_PC]);
    check_value("res_wen_o", 32'(res_wen_o), vec_mem[base + F_WEN]);
    // rd and write data only mean something for a writer
    if (vec_mem[base + F_WEN][0]) begin
      check_value("res_rd_o", 32'(res_rd_o), vec_mem[base + F_RD]);
      check_value("res_wdata_o", res_wdata_o, vec_mem[base + F_WDATA]);
    end
    check_value("res_next_pc_o", res_next_pc_o, vec_mem[base + F_NEXT_PC]);
    check_value("res_store_o", 32'(res_store_o), vec_mem[base + F_STORE]);
    if (vec_mem[base + F_STORE][0]) begin
      check_value("res_store_addr_o", res_store_addr_o, vec_mem[base + F_ADDR]);
      check_value("res_store_data_o", res_store_data_o, vec_mem[base + F_DATA]);
      check_value("res_store_strb_o", 32'(res_store_strb_o), vec_mem[base + F_STRB]);
    end
    check_value("res_illegal_o", 32'(res_illegal_o), vec_mem[base + F_ILLEGAL]);
  endtask

  // input side and retire back-pressure share one random stream
  initial begin : drive
    int   sent;
    logic fire;
    logic offering;
    logic gap_a, gap_b;
    logic rdy_a, rdy_b;
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    in_inst_i   = '0;
    in_pc_i     = '0;
    res_ready_i = 1'b0;
    lfsr_q      = 32'hfef7;
    sent        = 0;
    offering    = 1'b0;
    $readmemh("test/core_vectors.txt", vec_mem);
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    while (retired < NUM_VEC) begin
      @(negedge clk);
      fire = in_valid_i && in_ready_o;
      @(posedge clk);
      if (fire) begin
        sent++;
      end
      // ready about three cycles in four
      random_bit(rdy_a);
      random_bit(rdy_b);
      res_ready_i <= rdy_a | rdy_b;
      if (fire || !offering) begin
        random_bit(gap_a);
        random_bit(gap_b);
        offering = sent < NUM_VEC && !(gap_a && gap_b);
        in_valid_i <= offering;
        if (offering) begin
          in_inst_i <= vec_mem[sent * FIELDS + F_INST];
          in_pc_i   <= vec_mem[sent * FIELDS + F_PC];
        end
      end
    end
  end

  initial begin : monitor
    retired = 0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    check_value("in_ready_o", 32'(in_ready_o), 32'd1);
    check_value("res_valid_o", 32'(res_valid_o), 32'd0);
    while (retired < NUM_VEC) begin
      @(negedge clk);
      if (res_valid_o && res_ready_i) begin
        check_retire(retired);
        retired++;
      end
    end
    $display("Finished with no errors");
    $finish;
  end

  initial begin : watchdog
    repeat (LIMIT) @(posedge clk);
    $display("timeout: only %0d of %0d instructions retired in %0d cycles",
             retired, NUM_VEC, LIMIT);
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- test/core_vectors.txt
// inst pc rd wen wdata next_pc store store_addr store_data strb illegal
// all hex, fields that do not apply are zero
123450b7 00000100 01 1 12345000 00000104 0 00000000 00000000 0 0 // lui x1, 0x12345
67808093 00000104 01 1 12345678 00000108 0 00000000 00000000 0 0 // addi x1, x1, 0x678
00001117 00000108 02 1 00001108 0000010c 0 00000000 00000000 0 0 // auipc x2, 1
ff000193 0000010c 03 1 fffffff0 00000110 0 00000000 00000000 0 0 // addi x3, x0, -16
4021d213 00000110 04 1 fffffffc 00000114 0 00000000 00000000 0 0 // srai x4, x3, 2
0021d293 00000114 05 1 3ffffffc 00000118 0 00000000 00000000 0 0 // srli x5, x3, 2
40208333 00000118 06 1 12344570 0000011c 0 00000000 00000000 0 0 // sub x6, x1, x2
0011a3b3 0000011c 07 1 00000001 00000120 0 00000000 00000000 0 0 // slt x7, x3, x1
0011b433 00000120 08 1 00000000 00000124 0 00000000 00000000 0 0 // sltu x8, x3, x1
00500013 00000124 00 1 00000005 00000128 0 00000000 00000000 0 0 // addi x0, x0, 5
001004b3 00000128 09 1 12345678 0000012c 0 00000000 00000000 0 0 // add x9, x0, x1
0030c533 0000012c 0a 1 edcba988 00000130 0 00000000 00000000 0 0 // xor x10, x1, x3
0ff0f593 00000130 0b 1 00000078 00000134 0 00000000 00000000 0 0 // andi x11, x1, 0xff
0025e633 00000134 0c 1 00001178 00000138 0 00000000 00000000 0 0 // or x12, x11, x2
00859693 00000138 0d 1 00007800 0000013c 0 00000000 00000000 0 0 // slli x13, x11, 8
020007ef 0000013c 0f 1 00000140 0000015c 0 00000000 00000000 0 0 // jal x15, +0x20
00508867 00000140 10 1 00000144 1234567c 0 00000000 00000000 0 0 // jalr x16, 5(x1)
00908863 00000144 00 0 00000000 00000154 0 00000000 00000000 0 0 // beq x1, x9, +16
00909863 00000148 00 0 00000000 0000014c 0 00000000 00000000 0 0 // bne x1, x9, +16
fe11cce3 0000014c 00 0 00000000 00000144 0 00000000 00000000 0 0 // blt x3, x1, -8
0011d863 00000150 00 0 00000000 00000154 0 00000000 00000000 0 0 // bge x3, x1, +16
0011e863 00000154 00 0 00000000 00000158 0 00000000 00000000 0 0 // bltu x3, x1, +16
fe11fce3 00000158 00 0 00000000 00000150 0 00000000 00000000 0 0 // bgeu x3, x1, -8
001100a3 0000015c 00 0 00000000 00000160 1 00001109 34567800 2 0 // sb x1, 1(x2)
00111123 00000160 00 0 00000000 00000164 1 0000110a 56780000 c 0 // sh x1, 2(x2)
fe312c23 00000164 00 0 00000000 00000168 1 00001100 fffffff0 f 0 // sw x3, -8(x2)
00012883 00000168 00 0 00000000 0000016c 0 00000000 00000000 0 1 // lw x17, 0(x2)
00000073 0000016c 00 0 00000000 00000170 0 00000000 00000000 0 1 // ecall
0ff0000f 00000170 00 0 00000000 00000174 0 00000000 00000000 0 0 // fence
0000100f 00000174 00 0 00000000 00000178 0 00000000 00000000 0 0 // fence.i
00188913 00000178 12 1 00000001 0000017c 0 00000000 00000000 0 0 // addi x18, x17, 1
01290933 0000017c 12 1 00000002 00000180 0 00000000 00000000 0 0 // add x18, x18, x18
01290933 00000180 12 1 00000004 00000184 0 00000000 00000000 0 0 // add x18, x18, x18
40f809b3 00000184 13 1 00000004 00000188 0 00000000 00000000 0 0 // sub x19, x16, x15
0129a023 00000188 00 0 00000000 0000018c 1 00000004 00000004 f 0 // sw x18, 0(x19)
41355a33 0000018c 14 1 fedcba98 00000190 0 00000000 00000000 0 0 // sra x20, x10, x19
013a5ab3 00000190 15 1 0fedcba9 00000194 0 00000000 00000000 0 0 // srl x21, x20, x19
fe0a9ce3 00000194 00 0 00000000 0000018c 0 00000000 00000000 0 0 // bne x21, x0, -8
0000000b 00000198 00 0 00000000 0000019c 0 00000000 00000000 0 1 // custom-0 opcode

//--- project.f
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core_top.sv
test/tb_rv_core.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_rv_core
RTL_TOP    := rv_core_top
FILELIST   := project.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --assert --timing -j 0
LINT_FLAGS := --lint-only -Wall --assert
PASS_MSG   := Finished with no errors
RTL_SRCS   := $(filter logic/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
